//--- verilog/morph_settings.svh
// Build-time sizes of the dilation window and of the raster line
`ifndef MORPH_SETTINGS_SVH
`define MORPH_SETTINGS_SVH

// window side, odd so the window has a centre
`define MORPH_WINDOW_SIZE 5

`define MORPH_LINE_LENGTH 12 // samples per line, blanking included

// line delay depth is line length minus window size
`define MORPH_LINE_ADDR_WIDTH 3

`define MORPH_SAMPLE_WIDTH 6 // five flags plus the pixel

`endif

//--- verilog/morph_pkg.sv
// Sample word layout, structuring element and fill count of the dilation pipeline
`default_nettype none

`include "morph_settings.svh"

package morph_pkg;

  // bit positions in the packed sample word
  parameter int PIX_BIT         = 0;
  parameter int WIN_ENABLE_BIT  = 1;
  parameter int SPDIF_BIT       = 2;
  parameter int VBLANK_BIT      = 3;
  parameter int HBLANK_BIT      = 4;
  parameter int DATA_ENABLE_BIT = 5;

  // diamond mask, bit index is row * window + column
  parameter logic [`MORPH_WINDOW_SIZE*`MORPH_WINDOW_SIZE-1:0] structuring_element = {
    5'b00100,
    5'b01110,
    5'b11111,
    5'b01110,
    5'b00100
  };

  // cycles until the oldest window position holds a real sample
  parameter int FILL_CYCLES =
    (`MORPH_WINDOW_SIZE - 1) * `MORPH_LINE_LENGTH + `MORPH_WINDOW_SIZE + 1;

endpackage

`default_nettype wire

//--- verilog/window_sequencer.sv
// Input register, shared line delay address and pipeline fill tracking
`timescale 1ns/1ps
`default_nettype none

`include "morph_settings.svh"

module window_sequencer (
  input  wire                               clk,
  input  wire                               reset,
  input  wire                               data_enable,
  input  wire                               hblank,
  input  wire                               vblank,
  input  wire                               spdif,
  input  wire                               win_enable,
  input  wire                               pix,
  output logic [`MORPH_SAMPLE_WIDTH-1:0]    in_word,
  output logic [`MORPH_LINE_ADDR_WIDTH-1:0] line_addr,
  output logic                              filled
);

  import morph_pkg::*;

  localparam int LINE_DEPTH = `MORPH_LINE_LENGTH - `MORPH_WINDOW_SIZE;
  localparam int FILL_WIDTH = $clog2(FILL_CYCLES);
  localparam logic [`MORPH_LINE_ADDR_WIDTH-1:0] LAST_ADDR =
    `MORPH_LINE_ADDR_WIDTH'(LINE_DEPTH - 1);
  localparam logic [FILL_WIDTH-1:0] FILL_LAST = FILL_WIDTH'(FILL_CYCLES - 1);

  logic [FILL_WIDTH-1:0] fill_count;

  always_ff @(posedge clk)
  begin
    in_word[DATA_ENABLE_BIT] <= data_enable;
    in_word[HBLANK_BIT]      <= hblank;
    in_word[VBLANK_BIT]      <= vblank;
    in_word[SPDIF_BIT]       <= spdif;
    in_word[WIN_ENABLE_BIT]  <= win_enable;
    in_word[PIX_BIT]         <= pix;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      line_addr  <= '0;
      fill_count <= '0;
      filled     <= 1'b0;
    end
    else
    begin
      if (line_addr == LAST_ADDR)
      begin
        line_addr <= '0; // one pass per line of delay
      end
      else
      begin
        line_addr <= line_addr + 1'b1;
      end
      if (!filled)
      begin
        fill_count <= fill_count + 1'b1;
        if (fill_count == FILL_LAST)
        begin
          filled <= 1'b1; // sticks until next reset
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/line_stage.sv
// One image row of the window, a tap shift register followed by a line delay memory
`timescale 1ns/1ps
`default_nettype none

`include "morph_settings.svh"

module line_stage (
  input  wire                                                clk,
  input  wire                                                reset,
  input  wire  [`MORPH_LINE_ADDR_WIDTH-1:0]                  line_addr,
  input  wire  [`MORPH_SAMPLE_WIDTH-1:0]                     row_in,
  output logic [`MORPH_SAMPLE_WIDTH-1:0]                     row_out,
  output logic [`MORPH_WINDOW_SIZE*`MORPH_SAMPLE_WIDTH-1:0]  taps
);

  localparam int SW         = `MORPH_SAMPLE_WIDTH;
  localparam int WS         = `MORPH_WINDOW_SIZE;
  localparam int LINE_DEPTH = `MORPH_LINE_LENGTH - `MORPH_WINDOW_SIZE;

  logic [SW-1:0] line_mem [LINE_DEPTH];
  logic [SW-1:0] tap_last;

  assign tap_last = taps[(WS-1)*SW +: SW]; // oldest word of the row

  // tap 0 holds the newest word
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      taps <= '0;
    end
    else
    begin
      taps <= {taps[(WS-1)*SW-1:0], row_in}; // shift one slot per clock
    end
  end

  always_ff @(posedge clk)
  begin
    line_mem[line_addr] <= tap_last; // overwrites the word just read out
  end

  // The address comes back to each slot every LINE_DEPTH clocks, so the
  // word read here left the last tap exactly LINE_DEPTH cycles ago.
  assign row_out = line_mem[line_addr];

endmodule

`default_nettype wire

//--- verilog/dilation_kernel.sv
// Masked OR over the window and registered assembly of the output sample
`timescale 1ns/1ps
`default_nettype none

`include "morph_settings.svh"

module dilation_kernel (
  input  wire                                               clk,
  input  wire                                               reset,
  input  wire [`MORPH_WINDOW_SIZE*`MORPH_WINDOW_SIZE-1:0]   taps_all,
  input  wire [`MORPH_SAMPLE_WIDTH-1:0]                     center_word,
  input  wire                                               filled,
  output logic                                              data_enable_out,
  output logic                                              hblank_out,
  output logic                                              vblank_out,
  output logic                                              spdif_out,
  output logic                                              win_enable_out,
  output logic                                              pix_out
);

  import morph_pkg::*;

  logic [`MORPH_WINDOW_SIZE*`MORPH_WINDOW_SIZE-1:0] masked_taps;
  logic                                             hit;

  assign masked_taps = taps_all & structuring_element; // positions outside the shape drop out
  assign hit         = |masked_taps;

  always_ff @(posedge clk)
  begin
    if (reset || !filled)
    begin
      data_enable_out <= 1'b0; // window still holds unwritten memory
      hblank_out      <= 1'b0;
      vblank_out      <= 1'b0;
      spdif_out       <= 1'b0;
      win_enable_out  <= 1'b0;
      pix_out         <= 1'b0;
    end
    else
    begin
      data_enable_out <= center_word[DATA_ENABLE_BIT]; // flags follow the centre sample
      hblank_out      <= center_word[HBLANK_BIT];
      vblank_out      <= center_word[VBLANK_BIT];
      spdif_out       <= center_word[SPDIF_BIT];
      win_enable_out  <= center_word[WIN_ENABLE_BIT];
      pix_out         <= hit;
    end
  end

endmodule

`default_nettype wire

//--- verilog/morph_dilate_top.sv
// Binary dilation of a raster stream, sequencer feeding a cascade of line stages
`timescale 1ns/1ps
`default_nettype none

`include "morph_settings.svh"

module morph_dilate_top (
  input  wire  clk,
  input  wire  reset,
  input  wire  data_enable,
  input  wire  hblank,
  input  wire  vblank,
  input  wire  spdif,
  input  wire  win_enable,
  input  wire  pix,
  output logic data_enable_out,
  output logic hblank_out,
  output logic vblank_out,
  output logic spdif_out,
  output logic win_enable_out,
  output logic pix_out
);

  import morph_pkg::*;

  localparam int WS     = `MORPH_WINDOW_SIZE;
  localparam int SW     = `MORPH_SAMPLE_WIDTH;
  localparam int CENTER = (WS - 1) / 2;

  logic [SW-1:0]                     row_chain [WS]; // entry k feeds stage k
  logic [WS*SW-1:0]                  stage_taps [WS];
  logic [`MORPH_LINE_ADDR_WIDTH-1:0] line_addr;
  logic                              filled;
  logic [WS*WS-1:0]                  taps_all;
  logic [SW-1:0]                     center_word;

  window_sequencer i_sequencer (
    .clk(clk), .reset(reset), .data_enable(data_enable), .hblank(hblank),
    .vblank(vblank), .spdif(spdif), .win_enable(win_enable), .pix(pix),
    .in_word(row_chain[0]), .line_addr(line_addr), .filled(filled)
  );

  for (genvar k = 0; k < WS; k++)
  begin : g_stage
    if (k < WS - 1)
    begin : g_link
      line_stage i_stage (
        .clk(clk), .reset(reset), .line_addr(line_addr), .row_in(row_chain[k]),
        .row_out(row_chain[k+1]), .taps(stage_taps[k])
      );
    end
    else
    begin : g_last
      line_stage i_stage (
        .clk(clk), .reset(reset), .line_addr(line_addr), .row_in(row_chain[k]),
        .row_out(), .taps(stage_taps[k])
      );
    end
    for (genvar j = 0; j < WS; j++)
    begin : g_tap
      assign taps_all[k*WS + j] = stage_taps[k][j*SW + PIX_BIT]; // row-major
    end
  end

  assign center_word = stage_taps[CENTER][CENTER*SW +: SW];

  dilation_kernel i_kernel (
    .clk(clk), .reset(reset), .taps_all(taps_all), .center_word(center_word),
    .filled(filled), .data_enable_out(data_enable_out), .hblank_out(hblank_out),
    .vblank_out(vblank_out), .spdif_out(spdif_out), .win_enable_out(win_enable_out),
    .pix_out(pix_out)
  );

endmodule

`default_nettype wire

//--- tests/morph_dilate_tb.sv
// Testbench for the dilation pipeline, replays input and expected words from a hex file
`timescale 1ns/1ps
`default_nettype none

`include "morph_settings.svh"

module morph_dilate_tb;

  import morph_pkg::*;

  localparam int NUM_VECTORS    = 100;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = NUM_VECTORS + 40; // vectors plus reset and slack
  localparam int SW             = `MORPH_SAMPLE_WIDTH;
  localparam int NUM_WORDS      = 2 * NUM_VECTORS;

  logic clk;
  logic reset;
  logic data_enable;
  logic hblank;
  logic vblank;
  logic spdif;
  logic win_enable;
  logic pix;
  logic data_enable_out;
  logic hblank_out;
  logic vblank_out;
  logic spdif_out;
  logic win_enable_out;
  logic pix_out;

  logic [15:0] vectors [0:NUM_WORDS-1]; // even entry input, odd entry expected
  int          cycle_count    = 0;
  int          current_vector = 0;

  morph_dilate_top i_dut (
    .clk(clk), .reset(reset), .data_enable(data_enable), .hblank(hblank),
    .vblank(vblank), .spdif(spdif), .win_enable(win_enable), .pix(pix),
    .data_enable_out(data_enable_out), .hblank_out(hblank_out),
    .vblank_out(vblank_out), .spdif_out(spdif_out),
    .win_enable_out(win_enable_out), .pix_out(pix_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout, the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "stopped by cycle limit");
    end
  end

  task automatic check_value(input string name, input logic got, input logic expected);
    if (got !== expected)
    begin
      $display("CHECK FAILED vector %0d %s: got 0x%0h, expected 0x%0h",
               current_vector, name, got, expected);
      $display("Verification failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic drive_sample(input logic [SW-1:0] word);
    data_enable = word[DATA_ENABLE_BIT];
    hblank      = word[HBLANK_BIT];
    vblank      = word[VBLANK_BIT];
    spdif       = word[SPDIF_BIT];
    win_enable  = word[WIN_ENABLE_BIT];
    pix         = word[PIX_BIT];
  endtask

  // outputs seen one falling edge after the vector was driven
  task automatic check_sample(input int index);
    logic [SW-1:0] expected;
    expected       = vectors[2*index+1][SW-1:0];
    current_vector = index;
    check_value("data_enable_out", data_enable_out, expected[DATA_ENABLE_BIT]);
    check_value("hblank_out", hblank_out, expected[HBLANK_BIT]);
    check_value("vblank_out", vblank_out, expected[VBLANK_BIT]);
    check_value("spdif_out", spdif_out, expected[SPDIF_BIT]);
    check_value("win_enable_out", win_enable_out, expected[WIN_ENABLE_BIT]);
    check_value("pix_out", pix_out, expected[PIX_BIT]);
  endtask

  // entries never written keep a value wider than a sample word
  task automatic load_vectors();
    bit missing;
    missing = 1'b0;
    for (int k = 0; k < NUM_WORDS; k++)
    begin
      vectors[k] = 16'hc000 | 16'(k);
    end
    $readmemh("tests/dilation_testdata.hex", vectors);
    for (int k = 0; k < NUM_WORDS; k++)
    begin
      if (vectors[k] > 16'h003f)
      begin
        missing = 1'b1;
      end
    end
    if (missing)
    begin
      $display("test data file is missing, too short or holds a word wider than a sample");
      $display("Verification failed");
      $fatal(1, "no usable stimulus");
    end
  endtask

  initial
  begin
    reset       = 1'b1;
    data_enable = 1'b0;
    hblank      = 1'b0;
    vblank      = 1'b0;
    spdif       = 1'b0;
    win_enable  = 1'b0;
    pix         = 1'b0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0; // first sample goes in with the release
    for (int i = 0; i < NUM_VECTORS; i++)
    begin
      if (i > 0)
      begin
        @(negedge clk);
        check_sample(i - 1);
      end
      drive_sample(vectors[2*i][SW-1:0]);
    end
    @(negedge clk);
    check_sample(NUM_VECTORS - 1);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verilog
verilog/morph_pkg.sv
verilog/window_sequencer.sv
verilog/line_stage.sv
verilog/dilation_kernel.sv
verilog/morph_dilate_top.sv
tests/morph_dilate_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module morph_dilate_tb \
  -f flist.f -o morph_dilate_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/morph_dilate_sim > sim.log 2>&1
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1

//--- tests/dilation_testdata.hex
// input word, expected output word, one clock per line
// bits 5..0 data_enable hblank vblank spdif win_enable pix
0c 00
08 00
08 00
0c 00
08 00
08 00
0c 00
08 00
18 00
1c 00
18 00
18 00
0c 00
08 00
08 00
0c 00
08 00
08 00
0c 00
08 00
18 00
1c 00
18 00
18 00
0c 00
08 00
08 00
0c 00
08 00
08 00
0c 00
08 00
18 00
1c 00
18 00
18 00
24 00
22 00
23 00
26 00
22 00
22 00
26 00
21 00
10 00
14 00
10 00
10 00
24 00
22 00
22 00
26 00
22 00
22 00
26 09
20 0d
10 08
14 08
10 0d
10 09
24 19
22 1c
22 18
26 18
22 25
22 23
26 23
21 27
10 23
14 23
10 27
10 21
24 11
22 15
22 10
26 10
22 24
22 23
26 23
20 27
10 22
14 22
10 27
10 21
25 11
23 14
23 10
27 10
23 25
23 23
27 23
21 27
10 23
14 23
10 27
10 21
25 11
23 15
23 10
27 11
